// File: Bender.yml
package:
  name: arbiter_n_to_1_request

sources:
  - verilog/control_packet_pkg.sv
  - verilog/request_arbiter_cfg_pkg.sv
  - verilog/request_sync_fifo.sv
  - verilog/round_robin_arbiter.sv
  - verilog/arbiter_n_to_1_request.sv
  - target: test
    files:
      - testbench/arbiter_n_to_1_request_tb.sv

// File: build.f
verilog/control_packet_pkg.sv
verilog/request_arbiter_cfg_pkg.sv
verilog/request_sync_fifo.sv
verilog/round_robin_arbiter.sv
verilog/arbiter_n_to_1_request.sv
testbench/arbiter_n_to_1_request_tb.sv

// File: testbench/arbiter_n_to_1_request_tb.sv
// Lanes send only under credit; vertex id bits 31:30 carry the lane so the monitor can route packets
module arbiter_n_to_1_request_tb;

  localparam int NUM_LANES   = request_arbiter_cfg_pkg::NUM_REQUESTOR;
  localparam int NUM_TESTS   = 5;
  // Cycles the stall is held once all credits are down
  localparam int HOLD_CYCLES = 16;

  typedef enum int {
    POP_ALWAYS,
    POP_HOLD,
    POP_RANDOM
  } pop_mode_t;

  // --------------------------------------------------------------------------
  // Test table
  // --------------------------------------------------------------------------
  string     test_name [NUM_TESTS] = '{"single_lane", "all_lanes", "fairness",
                                       "backpressure", "random_traffic"};
  int        test_packets [NUM_TESTS] = '{20, 24, 8, 40, 30};
  logic [3:0] test_mask [NUM_TESTS] = '{4'b0010, 4'b1111, 4'b1111, 4'b1111, 4'b1111};
  pop_mode_t test_pop [NUM_TESTS] = '{POP_ALWAYS, POP_ALWAYS, POP_HOLD, POP_HOLD, POP_RANDOM};
  bit        test_fair [NUM_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

  // --------------------------------------------------------------------------
  // DUT signals
  // --------------------------------------------------------------------------
  logic                                ap_clk;
  logic                                areset_control;
  request_arbiter_cfg_pkg::lane_mask_t request_in_valid;
  control_packet_pkg::payload_t        request_in_payload [NUM_LANES];
  logic                                request_out_pop;
  logic                                request_out_valid;
  control_packet_pkg::payload_t        request_out_payload;
  logic                                out_fifo_empty;
  logic                                out_fifo_prog_full;
  request_arbiter_cfg_pkg::lane_mask_t arbiter_grant_out;
  logic                                fifo_setup_signal;

  // Reference queues per lane
  control_packet_pkg::payload_t expected_q [NUM_LANES][$];
  // Lane order of received packets in the current test
  int          out_lanes [$];
  string       cur_test;
  int          mismatch_count;
  int          other_errors;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] rng_state;

  arbiter_n_to_1_request dut (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .request_in_valid   (request_in_valid),
    .request_in_payload (request_in_payload),
    .request_out_pop    (request_out_pop),
    .request_out_valid  (request_out_valid),
    .request_out_payload(request_out_payload),
    .out_fifo_empty     (out_fifo_empty),
    .out_fifo_prog_full (out_fifo_prog_full),
    .arbiter_grant_out  (arbiter_grant_out),
    .fifo_setup_signal  (fifo_setup_signal)
  );

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [35:0] expected,
                             input logic [35:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    other_errors++;
    $display("ERROR %s: %s", cur_test, msg);
  endtask

  // Sliding windows of four while every lane still has output left
  task automatic check_fairness();
    logic [3:0] pending;
    logic [3:0] seen;
    int         n;
    n = out_lanes.size();
    for (int i = 0; i + 3 < n; i++) begin
      pending = '0;
      for (int j = i; j < n; j++) begin
        pending[out_lanes[j]] = 1'b1;
      end
      if (pending == 4'hF) begin
        seen = '0;
        for (int k = 0; k < 4; k++) begin
          seen[out_lanes[i+k]] = 1'b1;
        end
        check_value({cur_test, " window"}, 36'hF, seen);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // One table entry driven a little after each rising edge
  // --------------------------------------------------------------------------
  task automatic run_test(input int t);
    int         sent [NUM_LANES];
    logic [31:0] rnd;
    logic [3:0] mask;
    bit         holding;
    bit         saw_prog_full;
    bit         done;
    int         hold_left;
    cur_test = test_name[t];
    mask     = test_mask[t];
    out_lanes.delete();
    for (int i = 0; i < NUM_LANES; i++) begin
      sent[i] = 0;
    end
    holding       = (test_pop[t] == POP_HOLD);
    saw_prog_full = 1'b0;
    hold_left     = -1;
    done          = 1'b0;
    while (!done) begin
      @(posedge ap_clk);
      #2;
      rng_state = xorshift32(rng_state);
      rnd       = rng_state;
      for (int i = 0; i < NUM_LANES; i++) begin
        request_in_valid[i] = 1'b0;
        if (mask[i] && sent[i] < test_packets[t] && arbiter_grant_out[i] &&
            (test_pop[t] != POP_RANDOM || rnd[i])) begin
          rng_state = xorshift32(rng_state);
          // Opcode, lane, sequence, random filler
          request_in_payload[i] = {rng_state[31:28], 2'(i), 14'(sent[i]), rng_state[15:0]};
          expected_q[i].push_back(request_in_payload[i]);
          request_in_valid[i] = 1'b1;
          sent[i]++;
        end
      end
      // Stall phase where the output FIFO fills and credits drop
      if (holding) begin
        check_value({cur_test, " output while held"}, 36'h0, request_out_valid);
        // Without pops the output FIFO cannot fall back below its threshold
        if (saw_prog_full) begin
          check_value({cur_test, " prog_full held"}, 36'h1, out_fifo_prog_full);
        end else if (out_fifo_prog_full) begin
          saw_prog_full = 1'b1;
        end
        if (hold_left < 0) begin
          if (saw_prog_full && (arbiter_grant_out & mask) == '0) begin
            hold_left = HOLD_CYCLES;
          end
        end else begin
          check_value({cur_test, " credits held"}, 36'h0, arbiter_grant_out & mask);
          hold_left--;
          if (hold_left == 0) begin
            holding = 1'b0;
          end
        end
      end
      case (test_pop[t])
        POP_RANDOM: request_out_pop = rnd[8];
        POP_HOLD:   request_out_pop = ~holding;
        default:    request_out_pop = 1'b1;
      endcase
      done = !holding;
      for (int i = 0; i < NUM_LANES; i++) begin
        if ((mask[i] && sent[i] < test_packets[t]) || expected_q[i].size() != 0) begin
          done = 1'b0;
        end
      end
    end
    request_in_valid = '0;
    request_out_pop  = 1'b0;
    check_value({cur_test, " out_fifo_empty"}, 36'h1, out_fifo_empty);
    check_value({cur_test, " out_fifo_prog_full"}, 36'h0, out_fifo_prog_full);
    if (test_fair[t]) begin
      check_fairness();
    end
  endtask

  // --------------------------------------------------------------------------
  // Output monitor sampled just after the edge
  // --------------------------------------------------------------------------
  initial begin
    int lane;
    forever begin
      @(posedge ap_clk);
      #1;
      cycle_count++;
      if (!areset_control && request_out_valid) begin
        lane = int'(request_out_payload[31:30]);
        if (expected_q[lane].size() == 0) begin
          report_error($sformatf("lane %0d packet %h arrived with none pending",
                                 lane, request_out_payload));
        end else begin
          check_value(cur_test, expected_q[lane].pop_front(), request_out_payload);
          out_lanes.push_back(lane);
        end
      end
    end
  end

  // Watchdog on the cycle counter
  initial begin
    @(posedge ap_clk);
    while (cycle_count < cycle_limit) begin
      @(posedge ap_clk);
    end
    $display("Timeout after %0d cycles in test %s, the DUT stopped making progress",
             cycle_count, cur_test);
    $display("mismatches=%0d other_errors=%0d", mismatch_count, other_errors + 1);
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int total_packets;
    areset_control  = 1'b1;
    request_in_valid = '0;
    request_out_pop = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      request_in_payload[i] = '0;
    end
    mismatch_count = 0;
    other_errors   = 0;
    cycle_count    = 0;
    rng_state      = 32'h66f0_633a;
    cur_test       = "reset";
    total_packets  = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_packets += test_packets[t] * $countones(test_mask[t]);
    end
    cycle_limit = 40 * total_packets + 200;

    repeat (5) @(posedge ap_clk);
    #2;
    areset_control = 1'b0;
    check_value("reset out_valid", 36'h0, request_out_valid);
    check_value("reset credits", 36'h0, arbiter_grant_out);
    check_value("reset setup", 36'h1, fifo_setup_signal);
    // Credits stay down until setup is over
    while (fifo_setup_signal) begin
      check_value("setup credits", 36'h0, arbiter_grant_out);
      @(posedge ap_clk);
      #2;
    end
    while (arbiter_grant_out != 4'hF) begin
      check_value("setup flag", 36'h0, fifo_setup_signal);
      @(posedge ap_clk);
      #2;
    end

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end

    $display("mismatches=%0d other_errors=%0d", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : arbiter_n_to_1_request_tb

// File: verilog/arbiter_n_to_1_request.sv
// Lanes may send only while their credit is high; credit lags FIFO state by one cycle
module arbiter_n_to_1_request (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  request_arbiter_cfg_pkg::lane_mask_t request_in_valid,
  input  control_packet_pkg::payload_t        request_in_payload
                                              [request_arbiter_cfg_pkg::NUM_REQUESTOR],
  input  logic                                request_out_pop,
  output logic                                request_out_valid,
  output control_packet_pkg::payload_t        request_out_payload,
  output logic                                out_fifo_empty,
  output logic                                out_fifo_prog_full,
  output request_arbiter_cfg_pkg::lane_mask_t arbiter_grant_out,
  output logic                                fifo_setup_signal
);

  // --------------------------------------------------------------------------
  // Lane side signals
  // --------------------------------------------------------------------------
  // Registered lane inputs
  request_arbiter_cfg_pkg::lane_mask_t lane_valid_reg;
  control_packet_pkg::payload_t        lane_payload_reg [request_arbiter_cfg_pkg::NUM_REQUESTOR];

  // Lane FIFO outputs
  control_packet_pkg::payload_t        lane_dout [request_arbiter_cfg_pkg::NUM_REQUESTOR];
  request_arbiter_cfg_pkg::lane_mask_t lane_valid;
  request_arbiter_cfg_pkg::lane_mask_t lane_full;
  request_arbiter_cfg_pkg::lane_mask_t lane_empty;
  request_arbiter_cfg_pkg::lane_mask_t lane_prog_full;
  request_arbiter_cfg_pkg::lane_mask_t lane_busy;
  request_arbiter_cfg_pkg::lane_mask_t lane_rd_en;

  // --------------------------------------------------------------------------
  // Arbiter and output side signals
  // --------------------------------------------------------------------------
  request_arbiter_cfg_pkg::lane_mask_t arb_request;
  request_arbiter_cfg_pkg::lane_mask_t arb_grant;
  logic                                arb_enable;
  logic                                arb_out_valid;
  control_packet_pkg::payload_t        arb_out_payload;

  // Extra stage between arbiter and output FIFO
  logic                         out_wr_valid;
  control_packet_pkg::payload_t out_wr_payload;

  logic                         out_rd_en;
  control_packet_pkg::payload_t out_dout;
  logic                         out_valid;
  logic                         out_full;
  logic                         out_empty;
  logic                         out_prog_full;
  logic                         out_busy;

  // Any FIFO still in its reset window
  logic setup_int;

  // --------------------------------------------------------------------------
  // Input registers
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      lane_valid_reg <= '0;
    end else begin
      lane_valid_reg <= request_in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < request_arbiter_cfg_pkg::NUM_REQUESTOR; i++) begin
      lane_payload_reg[i] <= request_in_payload[i];
    end
  end

  // --------------------------------------------------------------------------
  // Lane FIFOs
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < request_arbiter_cfg_pkg::NUM_REQUESTOR; i++) begin : g_lane
    // Pop only the granted lane, and only if it holds data
    assign lane_rd_en[i] = arb_grant[i] & ~lane_empty[i];

    request_sync_fifo #(
      .DEPTH      (request_arbiter_cfg_pkg::LANE_FIFO_DEPTH),
      .PROG_THRESH(request_arbiter_cfg_pkg::LANE_PROG_THRESH)
    ) u_lane_fifo (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .din           (lane_payload_reg[i]),
      .wr_en         (lane_valid_reg[i]),
      .rd_en         (lane_rd_en[i]),
      .dout          (lane_dout[i]),
      .valid         (lane_valid[i]),
      .full          (lane_full[i]),
      .empty         (lane_empty[i]),
      .prog_full     (lane_prog_full[i]),
      .reset_busy    (lane_busy[i])
    );
  end

  // --------------------------------------------------------------------------
  // Round-robin arbiter
  // --------------------------------------------------------------------------
  // Non-empty lanes request
  assign arb_request = ~lane_empty;
  // Hold off while the output FIFO is past its threshold
  assign arb_enable  = ~out_fifo_prog_full;

  round_robin_arbiter u_arbiter (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control),
    .enable          (arb_enable),
    .lane_request    (arb_request),
    .lane_bus_valid  (lane_valid),
    .lane_bus_payload(lane_dout),
    .lane_grant      (arb_grant),
    .bus_out_valid   (arb_out_valid),
    .bus_out_payload (arb_out_payload)
  );

  // Arbiter output registered once more
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_wr_valid <= 1'b0;
    end else begin
      out_wr_valid <= arb_out_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_wr_payload <= arb_out_payload;
  end

  // --------------------------------------------------------------------------
  // Output FIFO
  // --------------------------------------------------------------------------
  // Pops against an empty FIFO are ignored
  assign out_rd_en = request_out_pop & ~out_empty;

  request_sync_fifo #(
    .DEPTH      (request_arbiter_cfg_pkg::OUT_FIFO_DEPTH),
    .PROG_THRESH(request_arbiter_cfg_pkg::OUT_PROG_THRESH)
  ) u_out_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (out_wr_payload),
    .wr_en         (out_wr_valid),
    .rd_en         (out_rd_en),
    .dout          (out_dout),
    .valid         (out_valid),
    .full          (out_full),
    .empty         (out_empty),
    .prog_full     (out_prog_full),
    .reset_busy    (out_busy)
  );

  assign setup_int = out_busy | (|lane_busy);

  // --------------------------------------------------------------------------
  // Output registers, credits and setup flag
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_out_valid  <= 1'b0;
      out_fifo_empty     <= 1'b1;
      out_fifo_prog_full <= 1'b0;
      fifo_setup_signal  <= 1'b1;
      arbiter_grant_out  <= '0;
    end else begin
      request_out_valid  <= out_valid;
      out_fifo_empty     <= out_empty;
      out_fifo_prog_full <= out_prog_full;
      fifo_setup_signal  <= setup_int;
      // Credit needs room in both the lane FIFO and the output FIFO
      for (int i = 0; i < request_arbiter_cfg_pkg::NUM_REQUESTOR; i++) begin
        arbiter_grant_out[i] <= ~lane_prog_full[i] & ~out_prog_full & ~fifo_setup_signal;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    request_out_payload <= out_dout;
  end

  // Lanes send only under credit
  assert property (@(posedge ap_clk) disable iff (areset_control)
    (request_in_valid & ~arbiter_grant_out) == '0);

  // Threshold slack covers credit lag and arbiter pipeline, no FIFO ever fills
  assert property (@(posedge ap_clk) disable iff (areset_control)
    !(|lane_full) && !out_full);

endmodule : arbiter_n_to_1_request

// File: verilog/control_packet_pkg.sv
// Packet layout is fixed as opcode over vertex id, and every engine lane must agree on these widths
package control_packet_pkg;

  // --------------------------------------------------------------------------
  // Field widths
  // --------------------------------------------------------------------------
  localparam int OPCODE_W    = 4;
  localparam int VERTEX_ID_W = 32;

  // Opcode in the upper bits, vertex id below
  localparam int PAYLOAD_W   = OPCODE_W + VERTEX_ID_W;

  // --------------------------------------------------------------------------
  // Packet vector types
  // --------------------------------------------------------------------------
  typedef logic [OPCODE_W-1:0]    opcode_t;
  typedef logic [VERTEX_ID_W-1:0] vertex_id_t;
  typedef logic [PAYLOAD_W-1:0]   payload_t;

  // Build a payload from its two fields
  function automatic payload_t pack_payload(opcode_t opcode, vertex_id_t vertex_id);
    return {opcode, vertex_id};
  endfunction

  // Opcode field of a payload
  function automatic opcode_t payload_opcode(payload_t payload);
    return payload[PAYLOAD_W-1 -: OPCODE_W];
  endfunction

  // Vertex id field of a payload
  function automatic vertex_id_t payload_vertex_id(payload_t payload);
    return payload[VERTEX_ID_W-1:0];
  endfunction

endpackage : control_packet_pkg

// File: verilog/request_arbiter_cfg_pkg.sv
// FIFO depths must be powers of two, and each threshold must leave room for the credit and pipeline lag
package request_arbiter_cfg_pkg;

  // --------------------------------------------------------------------------
  // Lanes
  // --------------------------------------------------------------------------
  localparam int NUM_REQUESTOR = 4;

  // One bit per lane
  typedef logic [NUM_REQUESTOR-1:0]         lane_mask_t;
  // Lane number, used by the priority pointer
  typedef logic [$clog2(NUM_REQUESTOR)-1:0] lane_index_t;

  // --------------------------------------------------------------------------
  // FIFO sizing
  // --------------------------------------------------------------------------
  // Lane FIFO, 4 places of slack over the credit lag
  localparam int LANE_FIFO_DEPTH  = 16;
  localparam int LANE_PROG_THRESH = 12;

  // Output FIFO, wide slack for packets still in the arbiter pipeline
  localparam int OUT_FIFO_DEPTH   = 32;
  localparam int OUT_PROG_THRESH  = 16;

  // Cycles a FIFO stays busy once reset is released
  localparam int RESET_BUSY_CYCLES = 3;
  typedef logic [$clog2(RESET_BUSY_CYCLES+1)-1:0] busy_count_t;

endpackage : request_arbiter_cfg_pkg

// File: verilog/request_sync_fifo.sv
// DEPTH must be a power of two; writes when full or busy and reads when empty or busy are dropped
module request_sync_fifo #(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  control_packet_pkg::payload_t din,
  input  logic                         wr_en,
  input  logic                         rd_en,
  output control_packet_pkg::payload_t dout,
  output logic                         valid,
  output logic                         full,
  output logic                         empty,
  output logic                         prog_full,
  output logic                         reset_busy
);

  // --------------------------------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------------------------------
  control_packet_pkg::payload_t mem [DEPTH];

  // Pointers wrap naturally at DEPTH
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  // One extra bit so a full buffer can be counted
  logic [$clog2(DEPTH+1)-1:0] count;

  request_arbiter_cfg_pkg::busy_count_t busy_count;

  logic push;
  logic pop;

  // Accepted accesses only
  assign push = wr_en & ~full & ~reset_busy;
  assign pop  = rd_en & ~empty & ~reset_busy;

  // Flags straight from the occupancy count
  assign empty     = (count == '0);
  assign full      = (count == ($clog2(DEPTH+1))'(DEPTH));
  assign prog_full = (count >= ($clog2(DEPTH+1))'(PROG_THRESH));

  // --------------------------------------------------------------------------
  // Reset busy timer
  // --------------------------------------------------------------------------
  // Loaded during reset, counts down after release
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      busy_count <= request_arbiter_cfg_pkg::busy_count_t'(
                    request_arbiter_cfg_pkg::RESET_BUSY_CYCLES);
    end else if (busy_count != '0) begin
      busy_count <= busy_count - 1'b1;
    end
  end

  assign reset_busy = (busy_count != '0);

  // --------------------------------------------------------------------------
  // Pointers and count
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Registered read, dout follows rd_en by one cycle
  always_ff @(posedge ap_clk) begin
    if (pop) begin
      dout <= mem[rd_ptr];
    end
  end

  // Valid marks the cycle dout carries fresh data
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      valid <= 1'b0;
    end else begin
      valid <= pop;
    end
  end

  // --------------------------------------------------------------------------
  // Protocol checks on the producer and consumer
  // --------------------------------------------------------------------------
  assert property (@(posedge ap_clk) disable iff (areset_control)
    wr_en |-> !full);

  assert property (@(posedge ap_clk) disable iff (areset_control)
    rd_en |-> !empty);

  // Nothing touches the FIFO until setup is over
  assert property (@(posedge ap_clk) disable iff (areset_control)
    (wr_en || rd_en) |-> !reset_busy);

endmodule : request_sync_fifo

// File: verilog/round_robin_arbiter.sv
// Grants at most every other cycle, so a lane's empty flag settles before that lane is granted again
module round_robin_arbiter (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                enable,
  input  request_arbiter_cfg_pkg::lane_mask_t lane_request,
  input  request_arbiter_cfg_pkg::lane_mask_t lane_bus_valid,
  input  control_packet_pkg::payload_t        lane_bus_payload
                                              [request_arbiter_cfg_pkg::NUM_REQUESTOR],
  output request_arbiter_cfg_pkg::lane_mask_t lane_grant,
  output logic                                bus_out_valid,
  output control_packet_pkg::payload_t        bus_out_payload
);

  // Grant phase alternates with a settle phase
  typedef enum logic {
    ARB_GRANT,
    ARB_SETTLE
  } arb_state_t;

  arb_state_t                           state;
  request_arbiter_cfg_pkg::lane_index_t priority_ptr;
  request_arbiter_cfg_pkg::lane_index_t pick;
  logic                                 pick_found;
  int                                   scan_idx;
  control_packet_pkg::payload_t         bus_mux;

  // --------------------------------------------------------------------------
  // Lane selection
  // --------------------------------------------------------------------------
  // First requesting lane at or after the priority pointer
  always_comb begin
    pick       = priority_ptr;
    pick_found = 1'b0;
    scan_idx   = 0;
    for (int k = 0; k < request_arbiter_cfg_pkg::NUM_REQUESTOR; k++) begin
      scan_idx = (int'(priority_ptr) + k) % request_arbiter_cfg_pkg::NUM_REQUESTOR;
      if (!pick_found && lane_request[scan_idx]) begin
        pick       = request_arbiter_cfg_pkg::lane_index_t'(scan_idx);
        pick_found = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Grant FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state        <= ARB_GRANT;
      lane_grant   <= '0;
      priority_ptr <= '0;
    end else begin
      // Grant is a single-cycle pulse
      lane_grant <= '0;
      case (state)
        ARB_GRANT: begin
          if (enable && pick_found) begin
            lane_grant <= request_arbiter_cfg_pkg::lane_mask_t'(1) << pick;
            // Lane after the winner gets top priority next
            if (int'(pick) == request_arbiter_cfg_pkg::NUM_REQUESTOR - 1) begin
              priority_ptr <= '0;
            end else begin
              priority_ptr <= pick + 1'b1;
            end
            state <= ARB_SETTLE;
          end
        end
        ARB_SETTLE: begin
          state <= ARB_GRANT;
        end
        default: begin
          state <= ARB_GRANT;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Bus mux and output register
  // --------------------------------------------------------------------------
  // Only the lane granted a cycle earlier drives a valid bus
  always_comb begin
    bus_mux = '0;
    for (int i = 0; i < request_arbiter_cfg_pkg::NUM_REQUESTOR; i++) begin
      if (lane_bus_valid[i]) begin
        bus_mux = lane_bus_payload[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      bus_out_valid <= 1'b0;
    end else begin
      bus_out_valid <= |lane_bus_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    bus_out_payload <= bus_mux;
  end

  // Granted lane answers on its bus one cycle later and no other lane does
  assert property (@(posedge ap_clk) disable iff (areset_control)
    lane_bus_valid == $past(lane_grant));

endmodule : round_robin_arbiter
